/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then check the log
set -e

verilator --binary --timing --assert -j 0 \
	-f sim.f --top-module tb_img_motor -o sim_img_motor

./obj_dir/sim_img_motor 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* sim.f */
+incdir+src
src/motor_pkg.sv
src/frame_delay.sv
src/img_motor_ctl.sv
src/offset_step_lut.sv
src/step_motor_drv.sv
src/img_motor_top.sv
verif/tb_img_motor.sv

/* src/frame_delay.sv */
`timescale 1ns/1ps
`default_nettype none
`include "motor_consts.svh"

module frame_delay (
	input  logic clk,
	input  logic resetn,
	input  logic frame_pulse,
	output logic sample
);

	localparam int cnt_w = $clog2(`IMG_REC_DELAY + 1);

	logic [cnt_w-1:0] cnt;     // cycles left until the sample

	// a new frame always restarts the delay
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
		end else if (frame_pulse) begin
			cnt <= cnt_w'(`IMG_REC_DELAY);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// last count, so the strobe lands IMG_REC_DELAY cycles after the pulse
	assign sample = (cnt == cnt_w'(1));

	// frames too close together would collide with the sample point
	a_sample_not_on_pulse: assert property (
		@(posedge clk) disable iff (!resetn)
		!(sample && frame_pulse)
	);

endmodule

`default_nettype wire

/* src/img_motor_ctl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "motor_consts.svh"

module img_motor_ctl
	import motor_pkg::*;
(
	input  logic               clk,
	input  logic               resetn,
	input  move_req_t          req,
	input  img_sample_t        img,
	input  motor_stat_t        stat,
	output motor_cmd_t         cmd,
	output logic               rd_en,
	output logic [`IMG_W-1:0]  rd_addr,
	input  logic [`STEP_W-1:0] rd_data,
	output logic               exe_done
);

	logic               rec_en;
	logic [`STEP_W-1:0] rec_pos;    // motor position just after the frame
	logic [5:1]         pen;        // stage valid chain

	logic [`IMG_W-1:0]  win_l;
	logic [`IMG_W-1:0]  win_r;
	logic [`IMG_W-1:0]  pos_d;
	logic [`IMG_W-1:0]  pos_c;
	logic               valid_1;

	logic               lofl;       // left of window
	logic               rofr;       // right of window
	logic               lofd;       // left of target
	logic [`IMG_W-1:0]  diff_dc;
	logic [`IMG_W-1:0]  diff_cd;
	logic               valid_2;

	logic               in_win_3;
	logic               need_back_3;
	logic               valid_3;
	logic               in_win_4;
	logic               need_back_4;
	logic               valid_4;

	logic [`STEP_W-1:0] dst_pos;
	logic [`STEP_W-1:0] step_5;
	logic               in_win_5;
	logic               over_5;
	logic               valid_5;

	logic               m_start;
	logic               m_stop;
	logic               m_mod;
	logic [`STEP_W-1:0] m_step;
	logic               started;
	logic               run_over;
	logic               dyn_adjust;
	logic               reached;
	logic               start_now;

	frame_delay i_frame_delay (
		.clk         (clk),
		.resetn      (resetn),
		.frame_pulse (img.pulse),
		.sample      (rec_en)
	);

	always_ff @(posedge clk) begin
		if (rec_en)
			rec_pos <= stat.position;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			pen <= '0;
		else
			pen <= {pen[4:1], img.pulse && req.dep_img};
	end

	// stage 1 registers window bounds and image position
	always_ff @(posedge clk) begin
		if (img.pulse) begin
			win_l   <= req.img_dst - req.img_tol;
			win_r   <= req.img_dst + req.img_tol;
			pos_d   <= req.img_dst;
			pos_c   <= img.pos;
			valid_1 <= img.valid;
		end
	end

	// stage 2
	always_ff @(posedge clk) begin
		if (pen[1]) begin
			lofl    <= (pos_c < win_l);
			rofr    <= (pos_c > win_r);
			lofd    <= (pos_c < pos_d);
			diff_dc <= pos_d - pos_c;
			diff_cd <= pos_c - pos_d;
			valid_2 <= valid_1;
		end
	end

	// stage 3 looks up the absolute offset
	always_ff @(posedge clk) begin
		if (pen[2]) begin
			in_win_3    <= !lofl && !rofr;
			need_back_3 <= !lofd;
			rd_addr     <= lofd ? diff_dc : diff_cd;
			valid_3     <= valid_2;
		end
	end

	assign rd_en = pen[3];

	always_ff @(posedge clk) begin
		if (pen[3]) begin
			in_win_4    <= in_win_3;
			need_back_4 <= need_back_3;
			valid_4     <= valid_3;
		end
	end

	// stage 5 forms the destination in motor steps
	always_ff @(posedge clk) begin
		if (pen[4]) begin
			in_win_5 <= in_win_4;
			over_5   <= !in_win_4 && (need_back_4 != req.dir_back);   // wrong side
			dst_pos  <= need_back_4 ? rec_pos - rd_data : rec_pos + rd_data;
			step_5   <= rd_data;
			valid_5  <= valid_4;
		end
	end

	assign reached = req.dir_back ? ($signed(stat.position) <= $signed(dst_pos))
	                              : ($signed(stat.position) >= $signed(dst_pos));

	assign start_now = !started && !m_start &&
	                   (!req.dep_img ||
	                    (pen[5] && req.single_dir && !in_win_5 && !over_5));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_start <= 1'b0;
			m_stop  <= 1'b0;
			m_mod   <= 1'b0;
		end else begin
			m_start <= start_now;
			m_stop  <= pen[5] && valid_5 && req.single_dir && stat.running && reached;
			m_mod   <= pen[5] && valid_5 && req.single_dir && stat.running &&
			           dyn_adjust && !reached;
		end
	end

	// step 0 runs open ended until a valid frame
	always_ff @(posedge clk) begin
		if (start_now)
			m_step <= !req.dep_img ? req.step : (valid_5 ? step_5 : '0);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			started    <= 1'b0;
			run_over   <= 1'b0;
			dyn_adjust <= 1'b0;
		end else begin
			if (m_start)
				started <= 1'b1;
			if (stat.running)
				run_over <= 1'b1;
			if (start_now && req.dep_img && !valid_5)
				dyn_adjust <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			exe_done <= 1'b0;
		else if (req.single_dir && run_over && !stat.running)
			exe_done <= 1'b1;
	end

	assign cmd.start      = m_start;
	assign cmd.stop       = m_stop;
	assign cmd.speed      = req.speed;
	assign cmd.step       = m_step;
	assign cmd.dir        = req.dir_back;
	assign cmd.mod_remain = m_mod;
	// distance still to go from the current position
	assign cmd.new_remain = req.dir_back ? stat.position - dst_pos
	                                     : dst_pos - stat.position;

	// isolated pulses given the frame spacing
	a_strobe_len: assert property (
		@(posedge clk) disable iff (!resetn)
		(m_start || m_stop || m_mod) |=> !(m_start || m_stop || m_mod)
	);

	a_start_stop: assert property (
		@(posedge clk) disable iff (!resetn)
		!(m_start && m_stop)
	);

	// table data taken by stage 5 must come from a written entry
	a_rd_data_known: assert property (
		@(posedge clk) disable iff (!resetn)
		pen[4] |-> !$isunknown(rd_data)
	);

endmodule

`default_nettype wire

/* src/img_motor_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "motor_consts.svh"

module img_motor_top
	import motor_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  move_req_t   req,
	input  img_sample_t img,
	input  lut_wr_t     lut_wr,
	output motor_stat_t stat,
	output logic        exe_done
);

	motor_cmd_t         cmd;
	logic               rd_en;
	logic [`IMG_W-1:0]  rd_addr;
	logic [`STEP_W-1:0] rd_data;

	img_motor_ctl i_ctl (
		.clk      (clk),
		.resetn   (resetn),
		.req      (req),
		.img      (img),
		.stat     (stat),
		.cmd      (cmd),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.exe_done (exe_done)
	);

	offset_step_lut i_lut (
		.clk     (clk),
		.wr      (lut_wr),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	step_motor_drv i_drv (
		.clk    (clk),
		.resetn (resetn),
		.cmd    (cmd),
		.stat   (stat)
	);

endmodule

`default_nettype wire

/* src/motor_consts.svh */
`ifndef MOTOR_CONSTS_SVH
`define MOTOR_CONSTS_SVH

// image coordinate and table address width
`define IMG_W 12

// step count and motor position width
`define STEP_W 32

// clock cycles per motor step
`define SPEED_W 16

`define LUT_DEPTH (1 << `IMG_W)     // one entry per pixel offset

// frame pulse to motor position sample, in cycles
`define IMG_REC_DELAY 2

`endif

/* src/motor_pkg.sv */
`default_nettype none
`include "motor_consts.svh"

package motor_pkg;

	typedef struct packed {
		logic                single_dir;   // stop at target, then report done
		logic                dir_back;     // 1 moves the position down
		logic                dep_img;      // image move, else direct move
		logic [`IMG_W-1:0]   img_dst;
		logic [`IMG_W-1:0]   img_tol;      // half width of target window
		logic [`SPEED_W-1:0] speed;
		logic [`STEP_W-1:0]  step;         // direct move only
	} move_req_t;

	typedef struct packed {
		logic              pulse;          // one per frame
		logic              valid;
		logic [`IMG_W-1:0] pos;
	} img_sample_t;

	typedef struct packed {
		logic                start;
		logic                stop;
		logic [`SPEED_W-1:0] speed;
		logic [`STEP_W-1:0]  step;         // 0 runs without end
		logic                dir;
		logic                mod_remain;
		logic [`STEP_W-1:0]  new_remain;
	} motor_cmd_t;

	typedef struct packed {
		logic               running;
		logic [`STEP_W-1:0] position;      // two's complement
	} motor_stat_t;

	typedef struct packed {
		logic               en;
		logic [`IMG_W-1:0]  addr;
		logic [`STEP_W-1:0] data;
	} lut_wr_t;

endpackage

`default_nettype wire

/* src/offset_step_lut.sv */
`timescale 1ns/1ps
`default_nettype none
`include "motor_consts.svh"

module offset_step_lut
	import motor_pkg::*;
(
	input  logic               clk,
	input  lut_wr_t            wr,
	input  logic               rd_en,
	input  logic [`IMG_W-1:0]  rd_addr,
	output logic [`STEP_W-1:0] rd_data
);

	// steps per pixel offset, filled by the host
	logic [`STEP_W-1:0] mem [`LUT_DEPTH];

	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	// old data on a same-address write
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* src/step_motor_drv.sv */
`timescale 1ns/1ps
`default_nettype none
`include "motor_consts.svh"

module step_motor_drv
	import motor_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  motor_cmd_t  cmd,
	output motor_stat_t stat
);

	logic [`SPEED_W-1:0] speed_q;
	logic [`SPEED_W-1:0] rate_cnt;     // cycles to the next step
	logic                dir_q;
	logic [`STEP_W-1:0]  remain;
	logic                endless;      // started with step 0
	logic                running;
	logic [`STEP_W-1:0]  position;

	logic                tick;
	logic [`STEP_W-1:0]  rem_cur;
	logic                endless_cur;
	logic                step_now;

	assign tick        = running && (rate_cnt <= `SPEED_W'(1));
	assign rem_cur     = cmd.mod_remain ? cmd.new_remain : remain;   // reload first
	assign endless_cur = endless && !cmd.mod_remain;
	assign step_now    = tick && (endless_cur || rem_cur != '0);

	always_ff @(posedge clk) begin
		if (cmd.start) begin
			speed_q <= cmd.speed;
			dir_q   <= cmd.dir;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			rate_cnt <= '0;
		else if (cmd.start)
			rate_cnt <= cmd.speed;
		else if (tick)
			rate_cnt <= speed_q;
		else if (running)
			rate_cnt <= rate_cnt - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running <= 1'b0;
			remain  <= '0;
			endless <= 1'b0;
		end else if (cmd.stop) begin
			running <= 1'b0;
			remain  <= '0;
			endless <= 1'b0;
		end else if (cmd.start) begin
			running <= 1'b1;
			remain  <= cmd.step;
			endless <= (cmd.step == '0);
		end else if (running) begin
			endless <= endless_cur;
			if (step_now) begin
				if (!endless_cur)
					remain <= rem_cur - 1'b1;
				if (!endless_cur && rem_cur == `STEP_W'(1))
					running <= 1'b0;       // last step taken
			end else begin
				remain <= rem_cur;
				if (!endless_cur && rem_cur == '0)
					running <= 1'b0;       // re-target landed on the spot
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			position <= '0;
		else if (step_now && !cmd.stop && !cmd.start)
			position <= dir_q ? position - 1'b1 : position + 1'b1;
	end

	assign stat.running  = running;
	assign stat.position = position;

	// a re-target only arrives during a run
	a_mod_while_running: assert property (
		@(posedge clk) disable iff (!resetn)
		cmd.mod_remain |-> running
	);

endmodule

`default_nettype wire

/* verif/tb_img_motor.sv */
`timescale 1ns/1ps
`default_nettype none
`include "motor_consts.svh"

module tb_img_motor
	import motor_pkg::*;
();

	localparam int clk_period = 10;
	localparam int tab_size   = 64;      // offsets the tests use
	localparam int img_speed  = 4;
	localparam int lut_max    = 40;      // table values run from 8 to 39

	// direct runs, three image runs and the open ended lead-in
	localparam int run_cycles      = 20*4 + 15*3 + 10*2 + 3*lut_max*img_speed + 40;
	localparam int watchdog_cycles = run_cycles + 2*tab_size + 6*100;

	logic        clk;
	logic        resetn;
	move_req_t   req;
	img_sample_t img;
	lut_wr_t     lut_wr;
	motor_stat_t stat;
	logic        exe_done;

	logic [`STEP_W-1:0] lut_model [tab_size];   // what the host wrote
	integer             seed;

	img_motor_top i_dut (
		.clk      (clk),
		.resetn   (resetn),
		.req      (req),
		.img      (img),
		.lut_wr   (lut_wr),
		.stat     (stat),
		.exe_done (exe_done)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		stop_on_error();
	end

	task automatic stop_on_error();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_stat(input string name, input motor_stat_t got,
		input motor_stat_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s running/position got %0b/%0d, expected %0b/%0d",
				$time, name, got.running, $signed(got.position),
				exp.running, $signed(exp.position));
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0b, expected %0b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	function automatic logic [`STEP_W-1:0] rand_steps();
		return `STEP_W'(($random(seed) & 31) + 8);
	endfunction

	// image above the target moves the position down
	function automatic logic [`STEP_W-1:0] expected_dst(input logic [`STEP_W-1:0] rec,
		input int dst, input int pos);
		if (pos >= dst)
			return rec - lut_model[pos - dst];
		else
			return rec + lut_model[dst - pos];
	endfunction

	task automatic write_table(input int addr, input logic [`STEP_W-1:0] data);
		@(negedge clk);
		lut_wr.en   = 1'b1;
		lut_wr.addr = `IMG_W'(addr);
		lut_wr.data = data;
		@(negedge clk);
		lut_wr.en = 1'b0;
		lut_model[addr] = data;
	endtask

	task automatic apply_reset(input move_req_t r);
		@(negedge clk);
		resetn = 1'b0;
		req    = r;
		img    = '0;
		repeat (5) @(negedge clk);
		resetn = 1'b1;
	endtask

	// pulses one frame and returns the position the controller latches
	task automatic send_frame(input logic valid, input int pos,
		output logic [`STEP_W-1:0] rec);
		@(negedge clk);
		img.pulse = 1'b1;
		img.valid = valid;
		img.pos   = `IMG_W'(pos);
		@(negedge clk);
		img.pulse = 1'b0;
		repeat (`IMG_REC_DELAY - 1) @(negedge clk);
		rec = stat.position;
	endtask

	task automatic wait_running(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		while (stat.running !== level) begin
			if (n >= max_cycles) begin
				$display("%s did not happen within %0d cycles", what, max_cycles);
				stop_on_error();
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic count_run(input int max_cycles, output int cycles);
		wait_running(1'b1, 16, "motor start");
		cycles = 0;
		while (stat.running === 1'b1) begin
			if (cycles > max_cycles) begin
				$display("motor still running after %0d cycles", max_cycles);
				stop_on_error();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic direct_move(input logic single, input logic back, input int steps,
		input int speed);
		move_req_t          r;
		motor_stat_t        exp;
		logic [`STEP_W-1:0] start_pos;
		int                 cycles;
		r            = '0;
		r.single_dir = single;
		r.dir_back   = back;
		r.speed      = `SPEED_W'(speed);
		r.step       = `STEP_W'(steps);
		apply_reset(r);
		start_pos = stat.position;
		count_run(steps * speed + 16, cycles);
		check_count("running cycles", cycles, steps * speed);
		exp.running  = 1'b0;
		exp.position = back ? start_pos - `STEP_W'(steps) : start_pos + `STEP_W'(steps);
		check_stat("stat", stat, exp);
		check_bit("exe_done", exe_done, 1'b0);   // one cycle behind running
		@(negedge clk);
		check_bit("exe_done", exe_done, single);
		repeat (4) @(negedge clk);
		check_bit("exe_done", exe_done, single);
		check_stat("stat", stat, exp);
	endtask

	function automatic move_req_t image_req(input logic back, input int dst, input int tol);
		move_req_t r;
		r            = '0;
		r.single_dir = 1'b1;
		r.dep_img    = 1'b1;
		r.dir_back   = back;
		r.img_dst    = `IMG_W'(dst);
		r.img_tol    = `IMG_W'(tol);
		r.speed      = `SPEED_W'(img_speed);
		return r;
	endfunction

	task automatic image_move(input logic back, input int dst, input int tol, input int pos);
		motor_stat_t        exp;
		logic [`STEP_W-1:0] rec;
		int                 off;
		int                 cycles;
		apply_reset(image_req(back, dst, tol));
		send_frame(1'b1, pos, rec);
		off = (pos >= dst) ? pos - dst : dst - pos;
		count_run(lut_max * img_speed + 16, cycles);
		check_count("running cycles", cycles, int'(lut_model[off]) * img_speed);
		exp.running  = 1'b0;
		exp.position = expected_dst(rec, dst, pos);
		check_stat("stat", stat, exp);
		@(negedge clk);
		check_bit("exe_done", exe_done, 1'b1);
	endtask

	// the motor must stay put in the window or past the target
	task automatic idle_frame(input logic back, input int dst, input int tol, input int pos);
		motor_stat_t        exp;
		logic [`STEP_W-1:0] rec;
		apply_reset(image_req(back, dst, tol));
		exp.running  = 1'b0;
		exp.position = stat.position;
		send_frame(1'b1, pos, rec);
		repeat (30) begin
			@(negedge clk);
			check_bit("stat.running", stat.running, 1'b0);
		end
		check_stat("stat", stat, exp);
		check_bit("exe_done", exe_done, 1'b0);
	endtask

	task automatic dynamic_move(input int dst, input int tol, input int pos_a, input int pos_b);
		motor_stat_t        exp;
		logic [`STEP_W-1:0] rec;
		apply_reset(image_req(1'b0, dst, tol));
		send_frame(1'b0, pos_a, rec);       // no valid position gives an open ended run
		wait_running(1'b1, 16, "open ended start");
		repeat (20) @(negedge clk);
		check_bit("stat.running", stat.running, 1'b1);
		send_frame(1'b1, pos_b, rec);
		wait_running(1'b0, lut_max * img_speed + 16, "stop after re-target");
		exp.running  = 1'b0;
		exp.position = expected_dst(rec, dst, pos_b);
		check_stat("stat", stat, exp);
		@(negedge clk);
		check_bit("exe_done", exe_done, 1'b1);
	endtask

	initial begin
		resetn  = 1'b0;
		req     = '0;
		img     = '0;
		lut_wr  = '0;
		seed    = 71;
		// the table has no reset and is filled while the rest is held in reset
		for (int a = 0; a < tab_size; a++)
			write_table(a, rand_steps());

		direct_move(1'b1, 1'b0, 20, 4);
		direct_move(1'b1, 1'b1, 15, 3);
		direct_move(1'b0, 1'b0, 10, 2);     // no done without single_dir
		image_move(1'b0, 1000, 10, 980);
		idle_frame(1'b0, 1000, 10, 1005);
		idle_frame(1'b0, 1000, 10, 1030);   // above target with a forward request
		dynamic_move(1000, 10, 970, 985);

		write_table(24, rand_steps());
		write_table(24, rand_steps());      // latest write must win
		image_move(1'b1, 1000, 10, 1024);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
